// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axi_req_chimney
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hdl/chimney_pkg.sv
hdl/flit_link_if.sv
hdl/aw_w_packer.sv
hdl/ar_packer.sv
hdl/wormhole_arbiter.sv
hdl/axi_req_chimney.sv
test/tb_axi_req_chimney.sv

// File: hdl/ar_packer.sv
// AR packer
// Packs each AR beat into a single read request flit held in a one-entry
// output register
`timescale 1ns/1ps
`default_nettype none

module ar_packer (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  chimney_pkg::tile_id_t               src_id_i,
  input  logic                                ar_valid_i,
  input  logic [chimney_pkg::AddrWidth-1:0]   ar_addr_i,
  input  logic [chimney_pkg::AxiIdWidth-1:0]  ar_id_i,
  input  logic [chimney_pkg::LenWidth-1:0]    ar_len_i,
  output logic                                ar_ready_o,
  flit_link_if.producer                       out
);

  logic                     out_valid_q;
  chimney_pkg::flit_t       out_flit_q;
  chimney_pkg::flit_t       flit_d;
  chimney_pkg::ax_payload_t ax_payload;
  logic                     ar_fire;

  assign ar_ready_o = !out_valid_q || out.ready;
  assign ar_fire    = ar_valid_i && ar_ready_o;

  // A read request is always a one-flit packet
  always_comb begin
    ax_payload = '{addr: ar_addr_i, id: ar_id_i, len: ar_len_i};
    flit_d = '0;
    flit_d.hdr.dst_id = chimney_pkg::addr_to_dst(ar_addr_i);
    flit_d.hdr.src_id = src_id_i;
    flit_d.hdr.axi_ch = chimney_pkg::ChAr;
    flit_d.hdr.last   = 1'b1;
    flit_d.payload    = ax_payload;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else if (ar_fire) begin
      out_valid_q <= 1'b1;
    end else if (out.ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      out_flit_q <= flit_d;
    end
  end

  assign out.valid = out_valid_q;
  assign out.flit  = out_flit_q;

endmodule

`default_nettype wire

// File: hdl/aw_w_packer.sv
// AW/W packer
// Turns an AW beat into a header flit and the following W burst into data
// flits that follow the same destination, through a one-entry output register
`timescale 1ns/1ps
`default_nettype none

module aw_w_packer (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  chimney_pkg::tile_id_t               src_id_i,
  input  logic                                aw_valid_i,
  input  logic [chimney_pkg::AddrWidth-1:0]   aw_addr_i,
  input  logic [chimney_pkg::AxiIdWidth-1:0]  aw_id_i,
  input  logic [chimney_pkg::LenWidth-1:0]    aw_len_i,
  output logic                                aw_ready_o,
  input  logic                                w_valid_i,
  input  logic [chimney_pkg::DataWidth-1:0]   w_data_i,
  input  logic                                w_last_i,
  output logic                                w_ready_o,
  flit_link_if.producer                       out
);

  typedef enum logic {PhaseAw, PhaseW} phase_e;

  phase_e                   phase_q;
  chimney_pkg::tile_id_t    dst_q;
  logic                     out_valid_q;
  chimney_pkg::flit_t       out_flit_q;
  chimney_pkg::flit_t       flit_d;
  chimney_pkg::ax_payload_t ax_payload;
  logic                     load_ready;
  logic                     aw_fire;
  logic                     w_fire;

  // Register can take a new flit when empty or draining this cycle
  assign load_ready = !out_valid_q || out.ready;

  assign aw_ready_o = (phase_q == PhaseAw) && load_ready;
  assign w_ready_o  = (phase_q == PhaseW) && load_ready;
  assign aw_fire    = aw_valid_i && aw_ready_o;
  assign w_fire     = w_valid_i && w_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Flit packing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ax_payload = '{addr: aw_addr_i, id: aw_id_i, len: aw_len_i};
    flit_d = '0;
    flit_d.hdr.src_id = src_id_i;
    if (phase_q == PhaseAw) begin
      flit_d.hdr.dst_id = chimney_pkg::addr_to_dst(aw_addr_i);
      flit_d.hdr.axi_ch = chimney_pkg::ChAw;
      flit_d.hdr.last   = 1'b0;
      flit_d.payload    = ax_payload;
    end else begin
      // Data beats reuse the destination latched from AW
      flit_d.hdr.dst_id = dst_q;
      flit_d.hdr.axi_ch = chimney_pkg::ChW;
      flit_d.hdr.last   = w_last_i;
      flit_d.payload    = {{(chimney_pkg::PayloadWidth-chimney_pkg::DataWidth){1'b0}},
                           w_data_i};
    end
  end

  // Burst phase
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q <= PhaseAw;
    end else if (aw_fire) begin
      phase_q <= PhaseW;
    end else if (w_fire && w_last_i) begin
      phase_q <= PhaseAw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      dst_q <= chimney_pkg::addr_to_dst(aw_addr_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else if (aw_fire || w_fire) begin
      out_valid_q <= 1'b1;
    end else if (out.ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire || w_fire) begin
      out_flit_q <= flit_d;
    end
  end

  assign out.valid = out_valid_q;
  assign out.flit  = out_flit_q;

endmodule

`default_nettype wire

// File: hdl/axi_req_chimney.sv
// AXI request chimney
// Outbound request half of the network interface. AW/W and AR beats from an
// AXI manager are packed into flits and merged onto one request link
`timescale 1ns/1ps
`default_nettype none

module axi_req_chimney (
  input  logic                                clk_i,
  input  logic                                reset_i,
  // Id of this tile
  input  chimney_pkg::tile_id_t               id_i,
  // AW channel
  input  logic                                aw_valid_i,
  input  logic [chimney_pkg::AddrWidth-1:0]   aw_addr_i,
  input  logic [chimney_pkg::AxiIdWidth-1:0]  aw_id_i,
  input  logic [chimney_pkg::LenWidth-1:0]    aw_len_i,
  output logic                                aw_ready_o,
  // W channel
  input  logic                                w_valid_i,
  input  logic [chimney_pkg::DataWidth-1:0]   w_data_i,
  input  logic                                w_last_i,
  output logic                                w_ready_o,
  // AR channel
  input  logic                                ar_valid_i,
  input  logic [chimney_pkg::AddrWidth-1:0]   ar_addr_i,
  input  logic [chimney_pkg::AxiIdWidth-1:0]  ar_id_i,
  input  logic [chimney_pkg::LenWidth-1:0]    ar_len_i,
  output logic                                ar_ready_o,
  // Request link to the NoC
  output logic                                req_valid_o,
  input  logic                                req_ready_i,
  output chimney_pkg::flit_t                  req_flit_o
);

  flit_link_if aw_w_link ();
  flit_link_if ar_link ();

  ////////////////////////////////////////////////////////////////////////////
  // Packers
  ////////////////////////////////////////////////////////////////////////////

  aw_w_packer u_aw_w_packer (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .src_id_i   ( id_i       ),
    .aw_valid_i ( aw_valid_i ),
    .aw_addr_i  ( aw_addr_i  ),
    .aw_id_i    ( aw_id_i    ),
    .aw_len_i   ( aw_len_i   ),
    .aw_ready_o ( aw_ready_o ),
    .w_valid_i  ( w_valid_i  ),
    .w_data_i   ( w_data_i   ),
    .w_last_i   ( w_last_i   ),
    .w_ready_o  ( w_ready_o  ),
    .out        ( aw_w_link  )
  );

  ar_packer u_ar_packer (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .src_id_i   ( id_i       ),
    .ar_valid_i ( ar_valid_i ),
    .ar_addr_i  ( ar_addr_i  ),
    .ar_id_i    ( ar_id_i    ),
    .ar_len_i   ( ar_len_i   ),
    .ar_ready_o ( ar_ready_o ),
    .out        ( ar_link    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration onto the request link
  ////////////////////////////////////////////////////////////////////////////

  wormhole_arbiter u_wormhole_arbiter (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .in_a        ( aw_w_link   ),
    .in_b        ( ar_link     ),
    .req_valid_o ( req_valid_o ),
    .req_ready_i ( req_ready_i ),
    .req_flit_o  ( req_flit_o  )
  );

endmodule

`default_nettype wire

// File: hdl/chimney_pkg.sv
// Request chimney package
// Shared widths, channel codes, the address map and the flit layout used
// by the AXI-to-NoC request path
`default_nettype none

package chimney_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned AxiIdWidth  = 4;
  localparam int unsigned LenWidth    = 8;
  localparam int unsigned TileIdWidth = 4;

  // Destination tile is taken from the top address bits
  localparam int unsigned AddrDstLsb = 28;

  // Sized for the larger AW/AR payload
  localparam int unsigned PayloadWidth = AddrWidth + AxiIdWidth + LenWidth;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ChAw = 2'd0,
    ChW  = 2'd1,
    ChAr = 2'd2
  } axi_ch_e;

  typedef logic [TileIdWidth-1:0] tile_id_t;

  typedef struct packed {
    tile_id_t dst_id;
    tile_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } flit_hdr_t;

  // Length sits in the low bits
  typedef struct packed {
    logic [AddrWidth-1:0]  addr;
    logic [AxiIdWidth-1:0] id;
    logic [LenWidth-1:0]   len;
  } ax_payload_t;

  typedef struct packed {
    flit_hdr_t               hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  function automatic tile_id_t addr_to_dst(input logic [AddrWidth-1:0] addr);
    return addr[AddrWidth-1:AddrDstLsb];
  endfunction

endpackage

`default_nettype wire

// File: hdl/flit_link_if.sv
// Flit link
// One valid/ready flit stream from a packer toward the arbiter
`timescale 1ns/1ps
`default_nettype none

interface flit_link_if;

  logic               valid;
  logic               ready;
  chimney_pkg::flit_t flit;

  // Packer side
  modport producer (
    output valid,
    output flit,
    input  ready
  );

  // Arbiter side
  modport consumer (
    input  valid,
    input  flit,
    output ready
  );

endinterface

`default_nettype wire

// File: hdl/wormhole_arbiter.sv
// Wormhole arbiter
// Round-robin choice between two flit links onto the request link; the grant
// is held from the first flit of a packet until its last flit has passed
`timescale 1ns/1ps
`default_nettype none

module wormhole_arbiter (
  input  logic                clk_i,
  input  logic                reset_i,
  flit_link_if.consumer       in_a,
  flit_link_if.consumer       in_b,
  output logic                req_valid_o,
  input  logic                req_ready_i,
  output chimney_pkg::flit_t  req_flit_o
);

  // Select encoding is 0 for in_a and 1 for in_b
  logic lock_q;
  logic last_sel_q;
  logic sel;
  logic xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      // Mid-packet, stay on the input that started it
      sel = last_sel_q;
    end else if (in_a.valid && in_b.valid) begin
      sel = !last_sel_q;
    end else begin
      sel = in_b.valid;
    end
  end

  assign req_valid_o = sel ? in_b.valid : in_a.valid;
  assign req_flit_o  = sel ? in_b.flit : in_a.flit;

  assign in_a.ready = !sel && req_ready_i;
  assign in_b.ready = sel && req_ready_i;

  assign xfer = req_valid_o && req_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Lock and round-robin state
  ////////////////////////////////////////////////////////////////////////////

  // Out of reset in_b counts as served last, so in_a has priority
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q     <= 1'b0;
      last_sel_q <= 1'b1;
    end else if (xfer) begin
      lock_q     <= !req_flit_o.hdr.last;
      last_sel_q <= sel;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_axi_req_chimney.sv
// Testbench for the AXI request chimney
// Random write bursts, reads and link back-pressure, checked against queues
// of expected flits built from the packing and address map rules
`timescale 1ns/1ps
`default_nettype none

module tb_axi_req_chimney;

  localparam int num_writes = 40;
  localparam int num_reads  = 60;
  localparam int max_len    = 7;
  localparam int flit_w     = $bits(chimney_pkg::flit_t);
  // Loose bound on cycles per flit with random gaps and back-pressure
  localparam int cycles_per_flit = 12;
  localparam int max_flits       = num_reads + num_writes * (max_len + 2);
  localparam longint timeout_ns  = (max_flits * cycles_per_flit + 200) * 10;

  logic                                clk_i = 1'b0;
  logic                                reset_i;
  chimney_pkg::tile_id_t               id_i;
  logic                                aw_valid_i;
  logic [chimney_pkg::AddrWidth-1:0]   aw_addr_i;
  logic [chimney_pkg::AxiIdWidth-1:0]  aw_id_i;
  logic [chimney_pkg::LenWidth-1:0]    aw_len_i;
  logic                                aw_ready_o;
  logic                                w_valid_i;
  logic [chimney_pkg::DataWidth-1:0]   w_data_i;
  logic                                w_last_i;
  logic                                w_ready_o;
  logic                                ar_valid_i;
  logic [chimney_pkg::AddrWidth-1:0]   ar_addr_i;
  logic [chimney_pkg::AxiIdWidth-1:0]  ar_id_i;
  logic [chimney_pkg::LenWidth-1:0]    ar_len_i;
  logic                                ar_ready_o;
  logic                                req_valid_o;
  logic                                req_ready_i;
  chimney_pkg::flit_t                  req_flit_o;

  int                    seed = 97899;
  logic [flit_w-1:0]     wr_q[$];
  logic [flit_w-1:0]     rd_q[$];
  chimney_pkg::tile_id_t burst_dst;
  int                    beats_left = 0;
  logic                  in_burst = 1'b0;
  logic                  served_write = 1'b0;
  logic                  drain = 1'b0;
  int                    reads_between = 0;
  int                    planned = 0;
  int                    received = 0;
  int                    err_reset = 0;
  int                    err_rd = 0;
  int                    err_wr = 0;
  int                    err_cnt = 0;
  int                    err_fair = 0;
  int                    tests_passed = 0;
  int                    tests_failed = 0;

  axi_req_chimney u_axi_req_chimney (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // Header is dst, src, channel, last; AW/AR payload is addr, id, len
  function automatic logic [flit_w-1:0] ax_flit(input logic [1:0] ch,
      input logic [31:0] addr, input logic [3:0] axid, input logic [7:0] len,
      input logic last);
    logic [chimney_pkg::TileIdWidth-1:0] dst;
    dst = addr[chimney_pkg::AddrWidth-1:chimney_pkg::AddrDstLsb];
    return {dst, id_i, ch, last, addr, axid, len};
  endfunction

  function automatic logic [flit_w-1:0] w_flit(input logic [3:0] dst,
      input logic [31:0] data, input logic last);
    logic [1:0] ch;
    ch = chimney_pkg::ChW;
    return {dst, id_i, ch, last, 12'd0, data};
  endfunction

  // Output flits are checked first, then this edge's accepted beats are queued
  always @(posedge clk_i) begin : flit_monitor
    logic [flit_w-1:0] got;
    logic [flit_w-1:0] expected;
    got = req_flit_o;
    if (!reset_i && req_valid_o && req_ready_i) begin
      received++;
      if (req_flit_o.hdr.axi_ch == chimney_pkg::ChAr) begin
        assert (!in_burst) else begin
          $display("ERROR at %0t: read flit inside a write burst", $time);
          err_wr++;
        end
        assert (served_write || wr_q.size() == 0) else begin
          $display("ERROR at %0t: read sent twice in a row while a write waited", $time);
          err_fair++;
        end
        if (wr_q.size() > 0) reads_between++;
        served_write = 1'b0;
        assert (rd_q.size() != 0) else begin
          $display("ERROR at %0t: read flit with no read outstanding", $time);
          err_cnt++;
        end
        if (rd_q.size() != 0) begin
          expected = rd_q.pop_front();
          assert (got == expected) else begin
            $display("MISMATCH at %0t: req_flit_o got %h expected %h", $time, got, expected);
            err_rd++;
          end
        end
      end else begin
        assert (in_burst || !served_write || rd_q.size() == 0) else begin
          $display("ERROR at %0t: write burst sent twice in a row while a read waited",
                   $time);
          err_fair++;
        end
        assert (wr_q.size() != 0) else begin
          $display("ERROR at %0t: write flit with no write outstanding", $time);
          err_cnt++;
        end
        if (wr_q.size() != 0) begin
          expected = wr_q.pop_front();
          assert (got == expected) else begin
            $display("MISMATCH at %0t: req_flit_o got %h expected %h", $time, got, expected);
            err_wr++;
          end
        end
        in_burst = !req_flit_o.hdr.last;
        if (req_flit_o.hdr.last) served_write = 1'b1;
      end
    end
    if (!reset_i && aw_valid_i && aw_ready_o) begin
      wr_q.push_back(ax_flit(chimney_pkg::ChAw, aw_addr_i, aw_id_i, aw_len_i, 1'b0));
      burst_dst  = aw_addr_i[chimney_pkg::AddrWidth-1:chimney_pkg::AddrDstLsb];
      beats_left = int'(aw_len_i) + 1;
    end
    if (!reset_i && w_valid_i && w_ready_o) begin
      beats_left--;
      wr_q.push_back(w_flit(burst_dst, w_data_i, beats_left == 0));
    end
    if (!reset_i && ar_valid_i && ar_ready_o) begin
      rd_q.push_back(ax_flit(chimney_pkg::ChAr, ar_addr_i, ar_id_i, ar_len_i, 1'b1));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (reset_i || drain) begin
      req_ready_i = drain;
    end else begin
      req_ready_i = (rand_word() & 32'd3) != 32'd0;
    end
  end

  // Half of the beats follow at once, the rest after up to 3 idle cycles
  task automatic idle_gap();
    logic [31:0] r;
    r = rand_word();
    if (r[2]) repeat (r[1:0]) @(negedge clk_i);
  endtask

  task automatic send_aw(input logic [31:0] r, input logic [7:0] len);
    aw_valid_i = 1'b1;
    aw_addr_i  = rand_word();
    aw_id_i    = r[11:8];
    aw_len_i   = len;
    @(posedge clk_i);
    while (!aw_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic send_w(input logic last);
    w_valid_i = 1'b1;
    w_data_i  = rand_word();
    w_last_i  = last;
    @(posedge clk_i);
    while (!w_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
  endtask

  task automatic send_ar();
    logic [31:0] r;
    r = rand_word();
    ar_valid_i = 1'b1;
    ar_addr_i  = rand_word();
    ar_id_i    = r[3:0];
    ar_len_i   = r[15:8];
    @(posedge clk_i);
    while (!ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic write_traffic();
    logic [31:0] r;
    logic [7:0]  len;
    for (int b = 0; b < num_writes; b++) begin
      r = rand_word();
      // Burst length 0 to 7
      len = {5'd0, r[2:0]};
      planned += int'(len) + 2;
      idle_gap();
      send_aw(r, len);
      for (int i = 0; i <= int'(len); i++) begin
        idle_gap();
        send_w(i == int'(len));
      end
    end
  endtask

  task automatic read_traffic();
    for (int n = 0; n < num_reads; n++) begin
      planned++;
      idle_gap();
      send_ar();
    end
  endtask

  task automatic report_result(input string name, input int errs);
    if (errs == 0) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s (%0d errors)", name, errs);
    end
  endtask

  initial begin : watchdog
    #(timeout_ns);
    $display("ERROR: no end of traffic after %0d ns, the run was stopped", timeout_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    logic [31:0] r;
    r           = rand_word();
    reset_i     = 1'b1;
    id_i        = r[3:0];
    aw_valid_i  = 1'b0;
    aw_addr_i   = '0;
    aw_id_i     = '0;
    aw_len_i    = '0;
    w_valid_i   = 1'b0;
    w_data_i    = '0;
    w_last_i    = 1'b0;
    ar_valid_i  = 1'b0;
    ar_addr_i   = '0;
    ar_id_i     = '0;
    ar_len_i    = '0;
    req_ready_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    assert (req_valid_o == 1'b0) else begin
      $display("MISMATCH at %0t: req_valid_o got %b expected 0", $time, req_valid_o);
      err_reset++;
    end
    assert (w_ready_o == 1'b0) else begin
      $display("MISMATCH at %0t: w_ready_o got %b expected 0", $time, w_ready_o);
      err_reset++;
    end
    report_result("reset state", err_reset);

    fork
      write_traffic();
      read_traffic();
    join
    drain = 1'b1;
    while (wr_q.size() != 0 || rd_q.size() != 0) @(negedge clk_i);
    // A few idle cycles so that any extra flit is caught
    repeat (8) @(negedge clk_i);

    assert (received == planned) else begin
      $display("MISMATCH at %0t: flit count got %0d expected %0d", $time, received, planned);
      err_cnt++;
    end
    assert (reads_between > 0) else begin
      $display("ERROR: no read flit was sent while writes were pending");
      err_fair++;
    end
    report_result("read flits", err_rd);
    report_result("write bursts", err_wr);
    report_result("flit count", err_cnt);
    report_result("read and write fairness", err_fair);
    $display("Tests: %0d passed, %0d failed, %0d flits checked",
             tests_passed, tests_failed, received);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
